/* Bender.yml */
package:
  name: rsc_lapo_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/rsc_dec_pkg.sv
      - verilog/rsc_dec_lapo.sv
      - verilog/rsc_dec_cfg_regs.sv
      - verilog/rsc_dec_decision.sv
      - verilog/rsc_lapo_top.sv
  - target: simulation
    files:
      - dv/tb_clkgen.sv
      - dv/tb_checker.sv
      - dv/tb_rsc_lapo.sv

/* dv/tb_checker.sv */
// testbench output checker
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
  input logic                          iclk,
  input logic                          ireset,
  input logic                          iclkena,
  input logic                          ival,
  input logic                          oval,
  input rsc_dec_pkg::lapo_t            olapo,
  input rsc_dec_pkg::extr_t            oextr,
  input logic [1:0]                    odec,
  input logic [rsc_dec_pkg::cfg_w-1:0] cfg_rdata
);

  import rsc_dec_pkg::*;

  logic [3*lapo_w-1:0] lapo_q [$];  // expected results, input order
  logic [3*extr_w-1:0] extr_q [$];
  logic [1:0]          dec_q [$];
  int                  in_q [$];    // enabled-cycle stamp per accepted ival
  int                  ena_cnt = 0;
  bit                  fresh = 0;   // last edge was enabled
  int                  mismatches = 0;
  int                  extras = 0;

  function automatic int pending();
    return dec_q.size();
  endfunction

  task automatic expect_item(input logic [3*lapo_w-1:0] lapo,
                             input logic [3*extr_w-1:0] extr,
                             input logic [1:0]          dec);
    lapo_q.push_back(lapo);
    extr_q.push_back(extr);
    dec_q.push_back(dec);
  endtask

  function automatic void compare(input string name, input logic signed [31:0] expected,
                                  input logic signed [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %0t %s expected %0d actual %0d", $time, name, expected, actual);
      mismatches++;
    end
  endfunction

  function automatic void check_rdata(input logic [cfg_w-1:0] expected);
    compare("cfg_rdata", expected, cfg_rdata);  // zero-extended field
  endfunction

  // --------------------------------------------------------------------------
  // input side, stamp each accepted item with its enabled cycle
  // --------------------------------------------------------------------------

  always @(posedge iclk) begin
    if (ireset) begin
      fresh = 1'b0;
    end else if (iclkena) begin
      if (ival) in_q.push_back(ena_cnt);
      ena_cnt++;
      fresh = 1'b1;
    end else begin
      fresh = 1'b0;  // frozen, outputs held
    end
  end

  task automatic check_item();
    logic [3*lapo_w-1:0] lapo_e;
    logic [3*extr_w-1:0] extr_e;
    logic [1:0]          dec_e;
    int                  t_in;
    lapo_e = lapo_q.pop_front();
    extr_e = extr_q.pop_front();
    dec_e  = dec_q.pop_front();
    t_in   = in_q.pop_front();
    compare("oval latency", 6, ena_cnt - t_in);  // in enabled cycles
    for (int i = 1; i <= 3; i++) begin
      compare($sformatf("olapo[%0d]", i), $signed(lapo_e[(i-1)*lapo_w +: lapo_w]), olapo[i]);
      compare($sformatf("oextr[%0d]", i), $signed(extr_e[(i-1)*extr_w +: extr_w]), oextr[i]);
    end
    compare("odec", dec_e, odec);
  endtask

  // --------------------------------------------------------------------------
  // output side, sampled mid-cycle
  // --------------------------------------------------------------------------

  always @(negedge iclk) begin
    if (!ireset && fresh) begin
      if (oval !== 1'b0 && oval !== 1'b1) begin
        $display("oval is unknown at %0t", $time);
        extras++;
      end else if (oval) begin
        if (dec_q.size() == 0 || in_q.size() == 0) begin
          $display("output at %0t has no matching input", $time);
          extras++;
        end else begin
          check_item();
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/tb_clkgen.sv */
// testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic iclk,
  output logic ireset
);

  initial begin
    iclk = 1'b0;
    forever #20 iclk = ~iclk;  // 40 ns period
  end

  // reset held over two rising edges
  initial begin
    ireset = 1'b1;
    repeat (2) @(posedge iclk);
    #5 ireset = 1'b0;  // released off the edge
  end

endmodule

`default_nettype wire

/* dv/tb_rsc_lapo.sv */
// rsc a-posteriori stage testbench
`timescale 1ns/1ns
`default_nettype none

module tb_rsc_lapo;

  import rsc_dec_pkg::*;

  localparam int n_rows = 24;

  logic             iclk, ireset, iclkena, ival;
  gamma_t           igamma;
  state_t           istate;
  logic             cfg_wr, cfg_addr;
  logic [cfg_w-1:0] cfg_wdata, cfg_rdata;
  logic             oval;
  lapo_t            olapo;
  extr_t            oextr;
  logic [1:0]       odec;

  // stimulus and expected results per row
  gamma_t              tab_gamma [n_rows];
  state_t              tab_state [n_rows];
  bit                  tab_hold  [n_rows];  // freeze before entry
  scale_t              tab_scale [n_rows];
  logic [sat_w-1:0]    tab_sat   [n_rows];
  logic [3*lapo_w-1:0] tab_lapo  [n_rows];
  logic [3*extr_w-1:0] tab_extr  [n_rows];
  logic [1:0]          tab_dec   [n_rows];

  scale_t           cur_scale = scale_full;  // register contents after reset
  logic [sat_w-1:0] cur_sat   = 5'd31;
  int               timeouts  = 0;
  bit               timed_out = 0;
  int unsigned      seed      = 32'he2867019;

  tb_clkgen    tb_clkgen_inst (.iclk(iclk), .ireset(ireset));
  rsc_lapo_top rsc_lapo_top_inst (.*);
  tb_checker   tb_checker_inst (.*);

  task automatic next_cycle();
    @(posedge iclk);
    #5;
  endtask

  // --------------------------------------------------------------------------
  // table setup
  // --------------------------------------------------------------------------

  task automatic fill_directed(input int r, input int c0, input int c1, input int c2,
                               input int c3, input int sv);
    for (int s = 0; s < n_states; s++) begin
      tab_gamma[r][s][0] = metric_t'(c0);
      tab_gamma[r][s][1] = metric_t'(c1);
      tab_gamma[r][s][2] = metric_t'(c2);
      tab_gamma[r][s][3] = metric_t'(c3);
      tab_state[r][s]    = metric_t'(sv);
    end
  endtask

  task automatic fill_table();
    fill_directed(0, 0, 0, 0, 0, 0);                 // all tie, dec 0
    fill_directed(1, 511, 511, 511, 511, 511);       // top of range
    fill_directed(2, -512, -512, -512, -512, -512);  // bottom of range
    fill_directed(3, 100, 0, 0, 0, 0);               // each symbol wins once
    fill_directed(4, 0, 100, 0, 0, 0);
    fill_directed(5, 0, 0, 100, 0, -3);
    fill_directed(6, 0, 0, 0, 100, 7);
    fill_directed(7, 0, 0, 77, 77, 0);               // tie 2/3 goes to 2
    fill_directed(8, -512, 511, -512, -512, 511);    // llr +1023
    fill_directed(9, 511, -512, -512, -512, -512);   // llr -1023
    for (int r = 0; r < n_rows; r++) begin
      if (r >= 10) begin
        for (int s = 0; s < n_states; s++) begin
          tab_state[r][s] = metric_t'($urandom);  // any 10b pair sum fits bm_w
          // small gamma keeps llrs around the clamp limits
          for (int u = 0; u < n_syms; u++) tab_gamma[r][s][u] = metric_t'(int'($urandom % 64) - 32);
        end
      end
      tab_hold[r]  = (r == 5) || (r == 8) || (r >= 10 && $urandom % 3 == 0);
      tab_scale[r] = (r < 10) ? scale_full : (r < 14) ? scale_3q :
                     (r < 18) ? scale_half : (r < 21) ? scale_off : scale_full;
      tab_sat[r]   = (r < 10) ? 5'd31 : (r < 14) ? 5'd20 : (r < 18) ? 5'd9 :
                     (r < 21) ? 5'd31 : 5'd3;
    end
  endtask

  // max-log over next-state branches, then scale, clamp and argmax
  task automatic build_expected(input int r);
    branch_t    best [n_syms];
    branch_t    sum;
    int         l, y, top;
    logic [1:0] dec;
    for (int u = 0; u < n_syms; u++) begin
      for (int s = 0; s < n_states; s++) begin
        sum = branch_t'(tab_gamma[r][s][u]) + branch_t'(tab_state[r][next_states[s][u]]);
        best[u] = (s == 0) ? sum : bm_max(best[u], sum);
      end
    end
    top = 0;
    dec = 2'd0;
    for (int i = 1; i <= 3; i++) begin
      l = int'(best[i]) - int'(best[0]);
      tab_lapo[r][(i-1)*lapo_w +: lapo_w] = lapo_w'(l);
      case (tab_scale[r])
        scale_full : y = l;
        scale_3q   : y = l - (l >>> 2);
        scale_half : y = l >>> 1;
        default    : y = 0;
      endcase
      if (y > int'(tab_sat[r])) y = int'(tab_sat[r]);
      else if (y < -int'(tab_sat[r])) y = -int'(tab_sat[r]);
      tab_extr[r][(i-1)*extr_w +: extr_w] = extr_w'(y);
      if (l > top) begin  // strict, lower index keeps a tie
        top = l;
        dec = 2'(i);
      end
    end
    tab_dec[r] = dec;
  endtask

  // --------------------------------------------------------------------------
  // register access and waits
  // --------------------------------------------------------------------------

  task automatic write_cfg(input logic addr, input logic [cfg_w-1:0] data);
    cfg_addr  = addr;
    cfg_wdata = data;
    cfg_wr    = 1'b1;
    next_cycle();
    cfg_wr    = 1'b0;
  endtask

  task automatic read_check(input logic addr, input logic [cfg_w-1:0] expected);
    cfg_addr = addr;
    @(negedge iclk);
    tb_checker_inst.check_rdata(expected);
    next_cycle();
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (ireset !== 1'b0 && n < 10) begin
      @(posedge iclk);
      n++;
    end
    if (ireset !== 1'b0) begin
      $display("timeout: reset was never released");
      timeouts++;
      timed_out = 1'b1;
    end
    next_cycle();
  endtask

  // empty the pipeline, clock enable dropped at random
  task automatic drain(input string what);
    int n;
    n = 0;
    ival = 1'b0;
    while (tb_checker_inst.pending() != 0 && n < 50) begin
      iclkena = ($urandom % 4 != 0);
      next_cycle();
      n++;
    end
    iclkena = 1'b1;
    if (tb_checker_inst.pending() != 0) begin
      $display("timeout: %0d results never came out while %s",
               tb_checker_inst.pending(), what);
      timeouts++;
      timed_out = 1'b1;
    end
  endtask

  task automatic apply_row(input int r);
    int stretch;
    if (tab_scale[r] != cur_scale || tab_sat[r] != cur_sat) begin
      drain("waiting to change the registers");
      if (timed_out) return;
      write_cfg(cfg_addr_scale, {6'b101101, tab_scale[r]});  // junk in unused bits
      write_cfg(cfg_addr_sat, {3'b111, tab_sat[r]});
      read_check(cfg_addr_scale, cfg_w'(tab_scale[r]));
      read_check(cfg_addr_sat, cfg_w'(tab_sat[r]));
      cur_scale = tab_scale[r];
      cur_sat   = tab_sat[r];
    end
    igamma = tab_gamma[r];
    istate = tab_state[r];
    ival   = 1'b1;
    if (tab_hold[r]) begin
      stretch = 1 + $urandom % 4;
      iclkena = 1'b0;  // item must not enter while frozen
      repeat (stretch) next_cycle();
    end
    iclkena = 1'b1;
    tb_checker_inst.expect_item(tab_lapo[r], tab_extr[r], tab_dec[r]);
    next_cycle();
    ival = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // run
  // --------------------------------------------------------------------------

  initial begin
    iclkena   = 1'b1;
    ival      = 1'b0;
    cfg_wr    = 1'b0;
    cfg_addr  = 1'b0;
    cfg_wdata = '0;
    for (int s = 0; s < n_states; s++) begin
      istate[s] = '0;
      for (int u = 0; u < n_syms; u++) igamma[s][u] = '0;
    end
    void'($urandom(seed));
    fill_table();
    for (int r = 0; r < n_rows; r++) build_expected(r);
    wait_reset();
    read_check(cfg_addr_scale, 8'd0);  // reset values
    read_check(cfg_addr_sat, 8'd31);
    for (int r = 0; r < n_rows && !timed_out; r++) apply_row(r);
    if (!timed_out) drain("draining the last results");
    $display("errors: %0d mismatches, %0d unexpected outputs, %0d timeouts",
             tb_checker_inst.mismatches, tb_checker_inst.extras, timeouts);
    if (tb_checker_inst.mismatches + tb_checker_inst.extras + timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* include/rsc_trellis.svh */
// duobinary rsc trellis
`ifndef rsc_trellis_svh
`define rsc_trellis_svh

// ---------------------------------------------------------------------------
// next state per current state and duobit symbol
// state update s' = rotl-like base(s) ^ map(sym), map = {0, 3, 6, 5}
// every state has four distinct successors and four predecessors
// ---------------------------------------------------------------------------

localparam logic [2:0] next_states [n_states][n_syms] = '{
  '{3'd0, 3'd3, 3'd6, 3'd5},  // s0
  '{3'd2, 3'd1, 3'd4, 3'd7},  // s1
  '{3'd4, 3'd7, 3'd2, 3'd1},  // s2
  '{3'd6, 3'd5, 3'd0, 3'd3},  // s3
  '{3'd5, 3'd6, 3'd3, 3'd0},  // s4
  '{3'd7, 3'd4, 3'd1, 3'd2},  // s5
  '{3'd1, 3'd2, 3'd7, 3'd4},  // s6
  '{3'd3, 3'd0, 3'd5, 3'd6}   // s7
};

// symbol index = {a, b} duobit pair
// column order 00, 01, 10, 11

`endif

/* rsc_lapo_top.f */
+incdir+include
verilog/rsc_dec_pkg.sv
verilog/rsc_dec_lapo.sv
verilog/rsc_dec_cfg_regs.sv
verilog/rsc_dec_decision.sv
verilog/rsc_lapo_top.sv
dv/tb_clkgen.sv
dv/tb_checker.sv
dv/tb_rsc_lapo.sv

/* verilog/rsc_dec_cfg_regs.sv */
// extrinsic control registers
`timescale 1ns/1ns
`default_nettype none

module rsc_dec_cfg_regs (
  input  logic                          iclk,
  input  logic                          ireset,
  input  logic                          cfg_wr,     // single-cycle strobe
  input  logic                          cfg_addr,
  input  logic [rsc_dec_pkg::cfg_w-1:0] cfg_wdata,
  output logic [rsc_dec_pkg::cfg_w-1:0] cfg_rdata,
  output rsc_dec_pkg::scale_t           scale,
  output logic [rsc_dec_pkg::sat_w-1:0] sat_limit
);

  import rsc_dec_pkg::*;

  // write side, free running w.r.t. clock enable
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      scale     <= scale_full;
      sat_limit <= sat_limit_rst;
    end else if (cfg_wr) begin
      case (cfg_addr)
        cfg_addr_scale : scale     <= cfg_wdata[1:0];        // upper bits dropped
        cfg_addr_sat   : sat_limit <= cfg_wdata[sat_w-1:0];
      endcase
    end
  end

  // readback, zero-extended
  always_comb begin
    case (cfg_addr)
      cfg_addr_scale : cfg_rdata = cfg_w'(scale);
      cfg_addr_sat   : cfg_rdata = cfg_w'(sat_limit);
    endcase
  end

endmodule

`default_nettype wire

/* verilog/rsc_dec_decision.sv */
// extrinsic scaling and hard decision
`timescale 1ns/1ns
`default_nettype none

module rsc_dec_decision (
  input  logic                          iclk,
  input  logic                          ireset,
  input  logic                          iclkena,
  input  logic                          ival,
  input  rsc_dec_pkg::lapo_t            ilapo,
  input  rsc_dec_pkg::scale_t           scale,
  input  logic [rsc_dec_pkg::sat_w-1:0] sat_limit,
  output logic                          oval,
  output rsc_dec_pkg::lapo_t            olapo,
  output rsc_dec_pkg::extr_t            oextr,
  output logic [1:0]                    odec
);

  import rsc_dec_pkg::*;

  logic signed [lapo_w-1:0] lim;            // +limit, zero-extended
  logic signed [lapo_w-1:0] scaled [1:3];
  logic signed [lapo_w-1:0] clipped [1:3];
  logic signed [lapo_w-1:0] best;           // running max, symbol 0 is 0
  logic [1:0]               dec;
  extr_t                    extr_c;

  assign lim = {{(lapo_w - sat_w){1'b0}}, sat_limit};

  // -------------------------------------------------------------------------
  // scale then clamp to +/- sat_limit
  // -------------------------------------------------------------------------

  always_comb begin
    for (int i = 1; i <= 3; i++) begin
      case (scale)
        scale_full : scaled[i] = ilapo[i];
        scale_3q   : scaled[i] = ilapo[i] - (ilapo[i] >>> 2);
        scale_half : scaled[i] = ilapo[i] >>> 1;
        scale_off  : scaled[i] = '0;
      endcase
      if (scaled[i] > lim) begin
        clipped[i] = lim;
      end else if (scaled[i] < -lim) begin
        clipped[i] = -lim;
      end else begin
        clipped[i] = scaled[i];
      end
      extr_c[i] = extr_w'(clipped[i]);  // |clipped| <= 31 always fits
    end
  end

  // argmax over {0, l1, l2, l3}, strict compare keeps lower index on tie
  always_comb begin
    best = '0;
    dec  = 2'd0;
    for (int i = 1; i <= 3; i++) begin
      if (ilapo[i] > best) begin
        best = ilapo[i];
        dec  = 2'(i);
      end
    end
  end

  // -------------------------------------------------------------------------
  // output stage
  // -------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else if (iclkena) begin
      oval <= ival;
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      olapo <= ilapo;   // unscaled copy
      oextr <= extr_c;
      odec  <= dec;
    end
  end

endmodule

`default_nettype wire

/* verilog/rsc_dec_lapo.sv */
// a-posteriori llr pipeline
`timescale 1ns/1ns
`default_nettype none

module rsc_dec_lapo (
  input  logic                iclk,
  input  logic                ireset,
  input  logic                iclkena,
  input  logic                ival,
  input  rsc_dec_pkg::gamma_t igamma,  // gamma_e + alpha[k]
  input  rsc_dec_pkg::state_t istate,  // beta[k+1]
  output logic                oval,
  output rsc_dec_pkg::lapo_t  olapo
);

  import rsc_dec_pkg::*;

  logic [4:0] val;  // one valid bit per stage

  bm_t     bm;                // stage 1
  branch_t tmp01   [n_syms];  // stage 2, layer 1
  branch_t tmp23   [n_syms];
  branch_t tmp45   [n_syms];
  branch_t tmp67   [n_syms];
  branch_t tmp0123 [n_syms];  // stage 3, layer 2
  branch_t tmp4567 [n_syms];
  branch_t tmp_llr [n_syms];  // stage 4, per-symbol max

  // -------------------------------------------------------------------------
  // valid tracking
  // -------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val <= '0;
    end else if (iclkena) begin
      val <= {val[3:0], ival};  // items shift together with data
    end
  end

  assign oval = val[4];

  // -------------------------------------------------------------------------
  // branch sums, forward direction only
  // bm(s, u) = gamma(s, u) + beta(next(s, u))
  // -------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      for (int s = 0; s < n_states; s++) begin
        for (int u = 0; u < n_syms; u++) begin
          bm[s][u] <= igamma[s][u] + istate[next_states[s][u]];  // sign-extends to bm_w
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // max-log reduction over the 8 states, three layers
  // -------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      for (int u = 0; u < n_syms; u++) begin
        if (val[0]) begin  // pairs
          tmp01[u] <= bm_max(bm[0][u], bm[1][u]);
          tmp23[u] <= bm_max(bm[2][u], bm[3][u]);
          tmp45[u] <= bm_max(bm[4][u], bm[5][u]);
          tmp67[u] <= bm_max(bm[6][u], bm[7][u]);
        end
        if (val[1]) begin  // quads
          tmp0123[u] <= bm_max(tmp01[u], tmp23[u]);
          tmp4567[u] <= bm_max(tmp45[u], tmp67[u]);
        end
        if (val[2]) begin
          tmp_llr[u] <= bm_max(tmp0123[u], tmp4567[u]);
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // llr relative to symbol 0
  // -------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && val[3]) begin
      for (int i = 1; i < n_syms; i++) begin
        olapo[i] <= tmp_llr[i] - tmp_llr[0];  // 11b - 11b fits lapo_w
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/rsc_dec_pkg.sv */
// rsc decoder shared definitions
`default_nettype none

package rsc_dec_pkg;

  // -------------------------------------------------------------------------
  // trellis and datapath widths
  // -------------------------------------------------------------------------

  localparam int n_states = 8;   // 8-state rsc
  localparam int n_syms   = 4;   // duobit symbols
  localparam int metric_w = 10;  // state / gamma metric
  localparam int bm_w     = 11;  // gamma + beta
  localparam int lapo_w   = 12;  // relative llr
  localparam int extr_w   = 6;   // extrinsic out
  localparam int sat_w    = 5;   // saturation limit field
  localparam int cfg_w    = 8;   // config data bus

  `include "rsc_trellis.svh"

  // -------------------------------------------------------------------------
  // metric types
  // -------------------------------------------------------------------------

  typedef logic signed [metric_w-1:0] metric_t;
  typedef metric_t gamma_t [n_states][n_syms];  // per state, per symbol
  typedef metric_t state_t [n_states];

  typedef logic signed [bm_w-1:0] branch_t;
  typedef branch_t bm_t [n_states][n_syms];

  typedef logic signed [lapo_w-1:0] lapo_t [1:3];  // llr vs symbol 0
  typedef logic signed [extr_w-1:0] extr_t [1:3];

  typedef logic [1:0] scale_t;

  // extrinsic scale codes
  localparam scale_t scale_full = 2'd0;
  localparam scale_t scale_3q   = 2'd1;  // x - (x >>> 2)
  localparam scale_t scale_half = 2'd2;  // x >>> 1
  localparam scale_t scale_off  = 2'd3;  // extrinsic forced to zero

  // config register map
  localparam logic cfg_addr_scale = 1'b0;
  localparam logic cfg_addr_sat   = 1'b1;

  localparam logic [sat_w-1:0] sat_limit_rst = 5'd31;  // widest clamp

  // -------------------------------------------------------------------------
  // max-log kernel
  // -------------------------------------------------------------------------

  function automatic branch_t bm_max(branch_t a, branch_t b);
    return (a > b) ? a : b;  // signed compare
  endfunction

endpackage

`default_nettype wire

/* verilog/rsc_lapo_top.sv */
// rsc a-posteriori output stage
`timescale 1ns/1ns
`default_nettype none

module rsc_lapo_top (
  input  logic                          iclk,
  input  logic                          ireset,
  input  logic                          iclkena,
  input  logic                          ival,
  input  rsc_dec_pkg::gamma_t           igamma,
  input  rsc_dec_pkg::state_t           istate,
  input  logic                          cfg_wr,
  input  logic                          cfg_addr,
  input  logic [rsc_dec_pkg::cfg_w-1:0] cfg_wdata,
  output logic [rsc_dec_pkg::cfg_w-1:0] cfg_rdata,
  output logic                          oval,
  output rsc_dec_pkg::lapo_t            olapo,
  output rsc_dec_pkg::extr_t            oextr,
  output logic [1:0]                    odec
);

  import rsc_dec_pkg::*;

  logic             lapo_val;   // 5 cycles after ival
  lapo_t            lapo;
  scale_t           scale;
  logic [sat_w-1:0] sat_limit;

  // -------------------------------------------------------------------------
  // llr pipeline, 5 enabled cycles
  // -------------------------------------------------------------------------

  rsc_dec_lapo rsc_dec_lapo_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .ival    (ival),
    .igamma  (igamma),
    .istate  (istate),
    .oval    (lapo_val),
    .olapo   (lapo)
  );

  rsc_dec_cfg_regs rsc_dec_cfg_regs_inst (
    .iclk      (iclk),
    .ireset    (ireset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .scale     (scale),
    .sat_limit (sat_limit)
  );

  // decision adds the sixth cycle
  rsc_dec_decision rsc_dec_decision_inst (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .ival      (lapo_val),
    .ilapo     (lapo),
    .scale     (scale),
    .sat_limit (sat_limit),
    .oval      (oval),
    .olapo     (olapo),
    .oextr     (oextr),
    .odec      (odec)
  );

endmodule

`default_nettype wire
